// File: include/lwc_params.svh
/*
 * Width and depth constants for the segment framer pipeline.
 * Included by the package and by every module that sizes a port or a counter.
 */
`ifndef LWC_PARAMS_SVH
`define LWC_PARAMS_SVH

// Public data and output word width
`define LWC_WORD_WIDTH 32

// Segment length field in a header word
`define LWC_LEN_WIDTH 16

// End-of-type flag position in a segment header
`define LWC_EOT_BIT 25

// Entries in the queue between parser and framer
`define LWC_FIFO_DEPTH 2

`endif

// File: src/lwc_pkg.sv
/*
 * Shared types of the segment framer: opcodes, output header types and
 * the item record passed between the pipeline stages.
 */
`default_nettype none

`include "lwc_params.svh"

package lwc_pkg;

    // Instruction opcodes in bits 31:28 of an instruction word
    typedef enum logic [3:0] {
        OP_ENC = 4'b0010,
        OP_DEC = 4'b0011
    } lwc_opcode_e;

    // Type nibble of the words sent on the output port
    typedef enum logic [3:0] {
        HDR_PLAINTEXT      = 4'b0100,
        HDR_CIPHERTEXT     = 4'b0101,
        HDR_STATUS_SUCCESS = 4'b1110
    } lwc_hdr_type_e;

    typedef enum logic {
        ITEM_HDR  = 1'b0,
        ITEM_DATA = 1'b1
    } lwc_item_kind_e;

    // Header items carry the segment length in the low bits of data
    typedef struct packed {
        lwc_item_kind_e              kind;
        logic [`LWC_WORD_WIDTH-1:0]  data;
        logic [2:0]                  size;
        logic                        seg_end;
        logic                        eot;
        logic                        decrypt;
    } lwc_item_t;

endpackage

`default_nettype wire

// File: src/lwc_segment_parser.sv
/*
 * First pipeline stage. Takes instruction, segment header and data words
 * from the public data input and emits one registered item per header or
 * data word, tagged with byte count, segment end and end-of-type.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lwc_params.svh"

module lwc_segment_parser (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`LWC_WORD_WIDTH-1:0]  pdi_data,
    input  logic                        pdi_valid,
    output logic                        pdi_ready,
    output lwc_pkg::lwc_item_t          parse_item,
    output logic                        parse_valid,
    input  logic                        parse_ready
);
    import lwc_pkg::*;

    localparam int WORD_W = `LWC_WORD_WIDTH;
    localparam int LEN_W = `LWC_LEN_WIDTH;
    localparam logic [LEN_W-1:0] WORD_BYTES = LEN_W'(4);

    typedef enum logic [1:0] {
        INSTRUCTION,
        HEADER,
        DATA
    } parse_state_e;

    parse_state_e      state;
    parse_state_e      state_next;
    logic              decrypt_q;
    logic              eot_q;
    logic [LEN_W-1:0]  remaining;
    logic [LEN_W-1:0]  remaining_next;
    logic [3:0]        opcode;
    logic [LEN_W-1:0]  seg_len;
    logic              seg_eot;
    logic              last_word;
    logic              pdi_fire;
    logic              item_load;
    lwc_item_t         next_item;

    // Accept when the output register is empty or drains this cycle
    assign pdi_ready = !parse_valid || parse_ready;
    assign pdi_fire = pdi_valid && pdi_ready;

    // Instruction words never produce an item
    assign item_load = pdi_fire && (state != INSTRUCTION);

    assign opcode = pdi_data[WORD_W-1 -: 4];
    assign seg_len = pdi_data[LEN_W-1:0];
    assign seg_eot = pdi_data[`LWC_EOT_BIT];
    assign last_word = (remaining <= WORD_BYTES);

    always_comb begin
        state_next = state;
        remaining_next = remaining;
        next_item = '0;
        next_item.decrypt = decrypt_q;
        case (state)
            INSTRUCTION: begin
                // Unknown opcodes are consumed and dropped
                if ((opcode == OP_ENC) || (opcode == OP_DEC)) begin
                    state_next = HEADER;
                end
            end
            HEADER: begin
                next_item.kind = ITEM_HDR;
                next_item.data = WORD_W'(seg_len);
                next_item.size = 3'd4;
                next_item.seg_end = (seg_len == '0);
                next_item.eot = seg_eot;
                remaining_next = seg_len;
                if (seg_len != '0) begin
                    state_next = DATA;
                end else if (seg_eot) begin
                    state_next = INSTRUCTION;
                end
            end
            DATA: begin
                next_item.kind = ITEM_DATA;
                next_item.data = pdi_data;
                next_item.eot = eot_q;
                next_item.seg_end = last_word;
                if (last_word) begin
                    // Final word of the segment may be partial
                    next_item.size = remaining[2:0];
                    remaining_next = '0;
                    if (eot_q) begin
                        state_next = INSTRUCTION;
                    end else begin
                        state_next = HEADER;
                    end
                end else begin
                    next_item.size = 3'd4;
                    remaining_next = remaining - WORD_BYTES;
                end
            end
            default: begin
                state_next = INSTRUCTION;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= INSTRUCTION;
            decrypt_q <= 1'b0;
            eot_q <= 1'b0;
            remaining <= '0;
            parse_valid <= 1'b0;
        end else begin
            if (pdi_fire) begin
                state <= state_next;
                remaining <= remaining_next;
            end
            if (pdi_fire && (state == INSTRUCTION)) begin
                decrypt_q <= (opcode == OP_DEC);
            end
            if (pdi_fire && (state == HEADER)) begin
                eot_q <= seg_eot;
            end
            if (item_load) begin
                parse_valid <= 1'b1;
            end else if (parse_ready) begin
                parse_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (item_load) begin
            parse_item <= next_item;
        end
    end

endmodule

`default_nettype wire

// File: src/lwc_word_fifo.sv
/*
 * Middle pipeline stage. A small circular queue of items that lets the
 * parser keep working while the output port is stalled.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lwc_params.svh"

module lwc_word_fifo (
    input  logic                clk,
    input  logic                reset,
    input  lwc_pkg::lwc_item_t  parse_item,
    input  logic                parse_valid,
    output logic                parse_ready,
    output lwc_pkg::lwc_item_t  queue_item,
    output logic                queue_valid,
    input  logic                queue_ready
);
    import lwc_pkg::*;

    localparam int DEPTH = `LWC_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    lwc_item_t         mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              wr_en;
    logic              rd_en;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign parse_ready = (count != CNT_W'(DEPTH));
    assign queue_valid = (count != '0);
    assign queue_item = mem[rd_ptr];

    assign wr_en = parse_valid && parse_ready;
    assign rd_en = queue_valid && queue_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Simultaneous push and pop leaves the count unchanged
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= parse_item;
        end
    end

endmodule

`default_nettype wire

// File: src/lwc_output_framer.sv
/*
 * Last pipeline stage. Turns queued items into output header and data
 * words and appends the success status word after an end-of-type segment.
 * The output port is a single register held while do_ready is low.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lwc_params.svh"

module lwc_output_framer (
    input  logic                        clk,
    input  logic                        reset,
    input  lwc_pkg::lwc_item_t          queue_item,
    input  logic                        queue_valid,
    output logic                        queue_ready,
    output logic [`LWC_WORD_WIDTH-1:0]  do_data,
    output logic                        do_valid,
    input  logic                        do_ready,
    output logic                        do_last
);
    import lwc_pkg::*;

    localparam int WORD_W = `LWC_WORD_WIDTH;
    localparam int LEN_W = `LWC_LEN_WIDTH;

    logic               out_free;
    logic               take;
    logic               status_pending;
    lwc_hdr_type_e      hdr_type;
    logic [3:0]         hdr_flags;
    logic [WORD_W-1:0]  item_word;
    logic [WORD_W-1:0]  status_word;

    // Output register can load when empty or accepted this cycle
    assign out_free = !do_valid || do_ready;
    assign queue_ready = out_free && !status_pending;
    assign take = queue_valid && queue_ready;

    assign status_word = {HDR_STATUS_SUCCESS, {(WORD_W-4){1'b0}}};

    // Decrypt reports plaintext and repeats eot in the last flag bit
    assign hdr_type = queue_item.decrypt ? HDR_PLAINTEXT : HDR_CIPHERTEXT;
    assign hdr_flags = {2'b00, queue_item.eot, queue_item.decrypt & queue_item.eot};

    always_comb begin
        if (queue_item.kind == ITEM_HDR) begin
            item_word = {hdr_type, hdr_flags, {(WORD_W-8-LEN_W){1'b0}},
                         queue_item.data[LEN_W-1:0]};
        end else begin
            item_word = queue_item.data;
            // First byte in the top lane and unused tail bytes cleared
            for (int i = 0; i < WORD_W / 8; i++) begin
                if (i >= int'(queue_item.size)) begin
                    item_word[WORD_W-1-8*i -: 8] = 8'h00;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            do_valid <= 1'b0;
            do_last <= 1'b0;
            status_pending <= 1'b0;
        end else if (out_free) begin
            if (status_pending) begin
                do_valid <= 1'b1;
                do_last <= 1'b1;
                status_pending <= 1'b0;
            end else if (take) begin
                do_valid <= 1'b1;
                do_last <= 1'b0;
                status_pending <= queue_item.seg_end && queue_item.eot;
            end else begin
                do_valid <= 1'b0;
                do_last <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (status_pending) begin
                do_data <= status_word;
            end else if (take) begin
                do_data <= item_word;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/lwc_framer_top.sv
/*
 * Segment framer top level. Parser, item queue and output framer in a
 * three-stage pipeline between the public data input and the output port.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lwc_params.svh"

module lwc_framer_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`LWC_WORD_WIDTH-1:0]  pdi_data,
    input  logic                        pdi_valid,
    output logic                        pdi_ready,
    output logic [`LWC_WORD_WIDTH-1:0]  do_data,
    output logic                        do_valid,
    input  logic                        do_ready,
    output logic                        do_last
);
    import lwc_pkg::*;

    lwc_item_t  parse_item;
    logic       parse_valid;
    logic       parse_ready;
    lwc_item_t  queue_item;
    logic       queue_valid;
    logic       queue_ready;

    lwc_segment_parser lwc_segment_parser_inst (
        .clk         (clk),
        .reset       (reset),
        .pdi_data    (pdi_data),
        .pdi_valid   (pdi_valid),
        .pdi_ready   (pdi_ready),
        .parse_item  (parse_item),
        .parse_valid (parse_valid),
        .parse_ready (parse_ready)
    );

    lwc_word_fifo lwc_word_fifo_inst (
        .clk         (clk),
        .reset       (reset),
        .parse_item  (parse_item),
        .parse_valid (parse_valid),
        .parse_ready (parse_ready),
        .queue_item  (queue_item),
        .queue_valid (queue_valid),
        .queue_ready (queue_ready)
    );

    lwc_output_framer lwc_output_framer_inst (
        .clk         (clk),
        .reset       (reset),
        .queue_item  (queue_item),
        .queue_valid (queue_valid),
        .queue_ready (queue_ready),
        .do_data     (do_data),
        .do_valid    (do_valid),
        .do_ready    (do_ready),
        .do_last     (do_last)
    );

endmodule

`default_nettype wire

// File: sim/lwc_framer_assert.sv
/*
 * Handshake checks on the segment framer, bound into the top level.
 * Covers output hold under back-pressure, reset state and the last flag.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lwc_params.svh"

module lwc_framer_assert (
    input logic                        clk,
    input logic                        reset,
    input logic [`LWC_WORD_WIDTH-1:0]  do_data,
    input logic                        do_valid,
    input logic                        do_ready,
    input logic                        do_last,
    input logic                        parse_valid,
    input logic                        queue_valid
);

    // Output word and last flag held while the sink stalls
    hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        (do_valid && !do_ready) |=> (do_valid && $stable(do_data) && $stable(do_last)))
        else $error("do_data or do_last changed while do_ready was low");

    // Nothing in flight the cycle after reset
    idle_after_reset: assert property (@(posedge clk)
        reset |=> (!parse_valid && !queue_valid && !do_valid && !do_last))
        else $error("valid signal high right after reset");

    last_with_valid: assert property (@(posedge clk) disable iff (reset)
        do_last |-> do_valid)
        else $error("do_last high without do_valid");

endmodule

bind lwc_framer_top lwc_framer_assert lwc_framer_assert_inst (
    .clk         (clk),
    .reset       (reset),
    .do_data     (do_data),
    .do_valid    (do_valid),
    .do_ready    (do_ready),
    .do_last     (do_last),
    .parse_valid (parse_valid),
    .queue_valid (queue_valid)
);

`default_nettype wire

// File: sim/tb_lwc_framer.sv
/*
 * Testbench for the segment framer. Reads input and expected output words
 * from the vector file, runs every test once with do_ready high and once
 * with random output stalls, and checks each output transfer.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lwc_params.svh"

module tb_lwc_framer;

    localparam int WORD_W = `LWC_WORD_WIDTH;
    localparam int CLK_PERIOD = 100;
    localparam int VEC_DEPTH = 64;
    localparam int NUM_PASSES = 2;
    localparam int CYCLES_PER_ENTRY = 200;

    // Tag nibble on top of each vector entry
    localparam logic [3:0] TAG_INPUT = 4'h1;
    localparam logic [3:0] TAG_EXPECT = 4'h2;
    localparam logic [3:0] TAG_EXPECT_LAST = 4'h3;
    localparam logic [3:0] TAG_END_FILE = 4'hE;
    localparam logic [3:0] TAG_END_TEST = 4'hF;

    logic               clk;
    logic               reset;
    logic [WORD_W-1:0]  pdi_data;
    logic               pdi_valid;
    logic               pdi_ready;
    logic [WORD_W-1:0]  do_data;
    logic               do_valid;
    logic               do_ready;
    logic               do_last;

    logic [WORD_W+3:0]  vectors [VEC_DEPTH];
    logic [WORD_W-1:0]  in_q [$];
    // Expected words with the last flag on top
    logic [WORD_W:0]    exp_q [$];
    int                 num_entries = 0;
    int                 error_count = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    integer             seed = 29;
    logic               stall_mode = 1'b0;

    lwc_framer_top lwc_framer_top_inst (
        .clk       (clk),
        .reset     (reset),
        .pdi_data  (pdi_data),
        .pdi_valid (pdi_valid),
        .pdi_ready (pdi_ready),
        .do_data   (do_data),
        .do_valid  (do_valid),
        .do_ready  (do_ready),
        .do_last   (do_last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input logic [WORD_W-1:0] actual,
                              input logic [WORD_W-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_last(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Fill the input and expected queues up to the next end-of-test tag
    task automatic load_test(inout int idx);
        logic [3:0]         tag;
        logic [WORD_W-1:0]  word;
        logic               done;
        done = 1'b0;
        while (!done && (idx < num_entries)) begin
            tag = vectors[idx][WORD_W+3 -: 4];
            word = vectors[idx][WORD_W-1:0];
            idx++;
            case (tag)
                TAG_INPUT: in_q.push_back(word);
                TAG_EXPECT: exp_q.push_back({1'b0, word});
                TAG_EXPECT_LAST: exp_q.push_back({1'b1, word});
                TAG_END_TEST: done = 1'b1;
                default: begin
                    $display("Vector entry %0d has an unknown tag %h", idx - 1, tag);
                    error_count++;
                    done = 1'b1;
                end
            endcase
        end
    endtask

    // Offered words stay until accepted with random valid gaps between them
    task automatic drive_inputs();
        logic [WORD_W-1:0] word;
        while (in_q.size() > 0) begin
            @(negedge clk);
            if (($random(seed) & 3) == 0) begin
                pdi_valid = 1'b0;
            end else begin
                word = in_q.pop_front();
                pdi_data = word;
                pdi_valid = 1'b1;
                while (!pdi_ready) begin
                    @(negedge clk);
                end
            end
        end
        @(negedge clk);
        pdi_valid = 1'b0;
    endtask

    // Output sink stalls only in the second pass
    initial begin
        forever begin
            @(negedge clk);
            if (stall_mode) begin
                do_ready = ($random(seed) & 1) != 0;
            end else begin
                do_ready = 1'b1;
            end
        end
    end

    always @(posedge clk) begin : monitor
        logic [WORD_W:0] expected;
        if (!reset && do_valid && do_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected output word %h at %0t ns", do_data, $time);
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                check_word(do_data, expected[WORD_W-1:0], "do_data");
                check_last(do_last, expected[WORD_W], "do_last");
            end
        end
    end

    initial begin : watchdog
        wait (num_entries > 0);
        #(num_entries * NUM_PASSES * CYCLES_PER_ENTRY * CLK_PERIOD);
        $display("Timeout: the DUT stopped moving words at %0t ns", $time);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int idx;
        int test_num;
        int errors_before;
        reset = 1'b1;
        pdi_data = '0;
        pdi_valid = 1'b0;
        do_ready = 1'b0;
        $readmemh("sim/lwc_framer_vectors.mem", vectors);
        while ((num_entries < VEC_DEPTH) &&
               (vectors[num_entries][WORD_W+3 -: 4] != TAG_END_FILE)) begin
            num_entries++;
        end
        if (num_entries == 0) begin
            $display("No test vectors were read");
            error_count++;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int pass_idx = 0; pass_idx < NUM_PASSES; pass_idx++) begin
            stall_mode = (pass_idx == 1);
            idx = 0;
            test_num = 0;
            while (idx < num_entries) begin
                test_num++;
                errors_before = error_count;
                load_test(idx);
                drive_inputs();
                while (exp_q.size() != 0) begin
                    @(negedge clk);
                end
                tests_run++;
                if (error_count != errors_before) begin
                    tests_failed++;
                    $display("Test %0d (%s): failed", test_num,
                             stall_mode ? "output stalls" : "no stalls");
                end else begin
                    $display("Test %0d (%s): passed", test_num,
                             stall_mode ? "output stalls" : "no stalls");
                end
            end
        end
        // Give a stray trailing word the chance to show up
        repeat (4) @(negedge clk);
        $display("Tests run: %0d, failed: %0d, check errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/lwc_framer_vectors.mem
// Each entry is a tag nibble and a 32-bit word. Tags: 1 input word, 2 expected output,
// 3 expected output with last, F end of test, E end of file
// Encrypt, one end-of-type segment of 8 bytes
120000000 142000008 111223344 155667788
252000008 211223344 255667788 3E0000000
F00000000
// Decrypt, 6-byte segment, tail of the second word cleared
130000000 152000006 1A1A2A3A4 1B1B2B3B4
243000006 2A1A2A3A4 2B1B20000 3E0000000
F00000000
// Two segments, status only after the end-of-type one
120000000 140000004 1CAFEF00D 142000003 1DEADBEEF
250000004 2CAFEF00D 252000003 2DEADBE00 3E0000000
F00000000
// Zero-length end-of-type segment
120000000 142000000
252000000 3E0000000
F00000000
// Unknown opcode dropped, then a normal encrypt
170000000 120000000 142000004 101020304
252000004 201020304 3E0000000
F00000000
E00000000

// File: project.f
+incdir+include
src/lwc_pkg.sv
src/lwc_segment_parser.sv
src/lwc_word_fifo.sv
src/lwc_output_framer.sv
src/lwc_framer_top.sv
sim/lwc_framer_assert.sv
sim/tb_lwc_framer.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_lwc_framer
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = ** FAIL **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@! grep -q -F "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
